// File: design/cache_pkg.sv
package cache_pkg;

    // geometry
    localparam int num_ways       = 4;
    localparam int num_sets       = 128;
    localparam int words_per_line = 8;
    localparam int tag_bits       = 20;
    localparam int index_bits     = 7;
    localparam int word_bits      = 3;

    // controller states
    localparam logic [2:0] st_idle     = 3'd0;
    localparam logic [2:0] st_lookup   = 3'd1;
    localparam logic [2:0] st_bus_req  = 3'd2;
    localparam logic [2:0] st_bus_recv = 3'd3;
    localparam logic [2:0] st_fill_cmp = 3'd4;

    // one address word, seen as cache fields or as segment plus physical
    typedef union packed {
        struct packed {
            logic [tag_bits-1:0]   tag;
            logic [index_bits-1:0] index;
            logic [word_bits-1:0]  word;
            logic [1:0]            byte_ofs;
        } cache;
        struct packed {
            logic [2:0]  seg;
            logic [28:0] phys;
        } map;
    } cache_addr_t;

    // root low picks ways 0-1 and root high picks ways 2-3
    // lo picks way 0 or 1 and hi picks way 2 or 3
    typedef struct packed {
        logic root;
        logic hi;
        logic lo;
    } plru_t;

endpackage

// File: design/bus_pkg.sv
package bus_pkg;

    // memory map segment codes in bits 31..29
    localparam logic [2:0] seg_kseg0 = 3'b100;
    localparam logic [2:0] seg_kseg1 = 3'b101;

    localparam int arlen_bits = 8;

    // beats minus one
    localparam logic [arlen_bits-1:0] line_burst_len   = 8'd7;
    localparam logic [arlen_bits-1:0] single_burst_len = 8'd0;

endpackage

// File: design/icache_ctrl.sv
`timescale 1ns/100ps

module icache_ctrl
    import cache_pkg::*, bus_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  inst_req,
    input  logic [31:0]           inst_addr,
    input  logic                  hit,
    input  logic [31:0]           hit_word,
    input  logic                  arready,
    input  logic [31:0]           rdata,
    input  logic                  rvalid,
    input  logic                  rlast,
    output logic [index_bits-1:0] array_index,
    output logic [word_bits-1:0]  array_word,
    output logic [tag_bits-1:0]   lookup_tag,
    output logic                  fill_we,
    output logic [word_bits-1:0]  fill_word,
    output logic                  fill_done,
    output logic                  hit_access,
    output logic                  inst_data_ok,
    output logic [31:0]           inst_rdata,
    output logic                  arvalid,
    output logic [31:0]           araddr,
    output logic [arlen_bits-1:0] arlen
);

    logic [2:0]           state;
    cache_addr_t          req_addr;
    cache_addr_t          addr_r;
    cache_addr_t          bus_addr;
    logic                 req_cached;
    logic                 cached_r;
    logic [word_bits-1:0] beat_cnt;
    logic [31:0]          capture_r;
    logic                 resp_r;

    assign req_addr   = inst_addr;
    assign req_cached = (req_addr.map.seg != seg_kseg1);

    // arrays see the new address during the request cycle
    assign array_index = inst_req ? req_addr.cache.index : addr_r.cache.index;
    assign array_word  = inst_req ? req_addr.cache.word : addr_r.cache.word;
    assign lookup_tag  = addr_r.cache.tag;

    always_ff @(posedge clk) begin
        if (inst_req) begin
            addr_r <= req_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= st_idle;
            cached_r <= 1'b0;
            beat_cnt <= '0;
            resp_r   <= 1'b0;
        end else begin
            resp_r <= (state == st_fill_cmp);
            case (state)
                st_idle: begin
                    if (inst_req) begin
                        cached_r <= req_cached;
                        state    <= req_cached ? st_lookup : st_bus_req;
                    end
                end
                st_lookup: begin
                    state <= hit ? st_idle : st_bus_req;
                end
                st_bus_req: begin
                    if (arready) begin
                        state <= st_bus_recv;
                    end
                end
                st_bus_recv: begin
                    if (rvalid) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (rlast) begin
                            beat_cnt <= '0;
                            state    <= st_fill_cmp;
                        end
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // keep the requested beat or the only beat of an uncached read
    always_ff @(posedge clk) begin
        if (state == st_bus_recv && rvalid &&
            (!cached_r || beat_cnt == addr_r.cache.word)) begin
            capture_r <= rdata;
        end
    end

    assign fill_we    = (state == st_bus_recv) && rvalid && cached_r;
    assign fill_word  = beat_cnt;
    assign fill_done  = (state == st_fill_cmp) && cached_r;
    assign hit_access = (state == st_lookup) && hit;

    assign inst_data_ok = hit_access || resp_r;
    assign inst_rdata   = resp_r ? capture_r : hit_word;

    // kseg0/kseg1 drop the top three bits and line fills start at word 0
    always_comb begin
        bus_addr = addr_r;
        if (addr_r.map.seg == seg_kseg0 || addr_r.map.seg == seg_kseg1) begin
            bus_addr.map.seg = 3'b000;
        end
        if (cached_r) begin
            bus_addr.cache.word     = '0;
            bus_addr.cache.byte_ofs = '0;
        end
    end

    assign arvalid = (state == st_bus_req);
    assign araddr  = bus_addr;
    assign arlen   = cached_r ? line_burst_len : single_burst_len;

endmodule

// File: design/icache_tag_array.sv
`timescale 1ns/100ps

module icache_tag_array
    import cache_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic [index_bits-1:0] array_index,
    input  logic [tag_bits-1:0]   lookup_tag,
    input  logic                  fill_done,
    input  logic [1:0]            victim_way,
    output logic                  hit,
    output logic [num_ways-1:0]   hit_way
);

    logic [tag_bits-1:0] tag_mem [num_ways][num_sets];
    logic [num_sets-1:0] valid [num_ways];
    logic [tag_bits-1:0] tag_q [num_ways];
    logic [num_ways-1:0] valid_q;

    always_ff @(posedge clk) begin
        for (int w = 0; w < num_ways; w++) begin
            tag_q[w] <= tag_mem[w][array_index];
        end
        if (fill_done) begin
            tag_mem[victim_way][array_index] <= lookup_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < num_ways; w++) begin
                valid[w] <= '0;
            end
            valid_q <= '0;
        end else begin
            for (int w = 0; w < num_ways; w++) begin
                valid_q[w] <= valid[w][array_index];
            end
            if (fill_done) begin
                valid[victim_way][array_index] <= 1'b1;
            end
        end
    end

    always_comb begin
        for (int w = 0; w < num_ways; w++) begin
            hit_way[w] = valid_q[w] && (tag_q[w] == lookup_tag);
        end
    end

    assign hit = |hit_way;

endmodule

// File: design/icache_data_array.sv
`timescale 1ns/100ps

module icache_data_array
    import cache_pkg::*;
(
    input  logic                  clk,
    input  logic [index_bits-1:0] array_index,
    input  logic [word_bits-1:0]  array_word,
    input  logic                  fill_we,
    input  logic [word_bits-1:0]  fill_word,
    input  logic [1:0]            victim_way,
    input  logic [31:0]           rdata,
    input  logic [num_ways-1:0]   hit_way,
    output logic [31:0]           hit_word
);

    logic [31:0] mem [num_ways][num_sets][words_per_line];
    logic [31:0] rd_q [num_ways];

    always_ff @(posedge clk) begin
        for (int w = 0; w < num_ways; w++) begin
            rd_q[w] <= mem[w][array_index][array_word];
        end
        // refill beats go into the victim way
        if (fill_we) begin
            mem[victim_way][array_index][fill_word] <= rdata;
        end
    end

    // only the one-hot hit way contributes
    always_comb begin
        hit_word = '0;
        for (int w = 0; w < num_ways; w++) begin
            if (hit_way[w]) begin
                hit_word = hit_word | rd_q[w];
            end
        end
    end

endmodule

// File: design/icache_plru.sv
`timescale 1ns/100ps

module icache_plru
    import cache_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic [index_bits-1:0] array_index,
    input  logic                  hit_access,
    input  logic [num_ways-1:0]   hit_way,
    input  logic                  fill_done,
    output logic [1:0]            victim_way
);

    plru_t       tree [num_sets];
    plru_t       cur;
    logic [1:0]  hit_idx;
    logic [1:0]  acc_way;

    assign cur = tree[array_index];

    // follow the tree bits down to a leaf
    assign victim_way = cur.root ? {1'b1, cur.hi} : {1'b0, cur.lo};

    always_comb begin
        hit_idx = 2'd0;
        for (int w = 0; w < num_ways; w++) begin
            if (hit_way[w]) begin
                hit_idx = w[1:0];
            end
        end
    end

    assign acc_way = hit_access ? hit_idx : victim_way;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < num_sets; s++) begin
                tree[s] <= '0;
            end
        end else if (hit_access || fill_done) begin
            // point the path away from the way just used
            tree[array_index].root <= ~acc_way[1];
            if (acc_way[1]) begin
                tree[array_index].hi <= ~acc_way[0];
            end else begin
                tree[array_index].lo <= ~acc_way[0];
            end
        end
    end

endmodule

// File: design/icache_top.sv
`timescale 1ns/100ps

module icache_top
    import cache_pkg::*, bus_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  inst_req,
    input  logic [31:0]           inst_addr,
    output logic                  inst_data_ok,
    output logic [31:0]           inst_rdata,
    output logic                  arvalid,
    input  logic                  arready,
    output logic [31:0]           araddr,
    output logic [arlen_bits-1:0] arlen,
    input  logic [31:0]           rdata,
    input  logic                  rvalid,
    input  logic                  rlast
);

    logic [index_bits-1:0] array_index;
    logic [word_bits-1:0]  array_word;
    logic [tag_bits-1:0]   lookup_tag;
    logic                  fill_we;
    logic [word_bits-1:0]  fill_word;
    logic                  fill_done;
    logic                  hit_access;
    logic                  hit;
    logic [num_ways-1:0]   hit_way;
    logic [31:0]           hit_word;
    logic [1:0]            victim_way;

    icache_ctrl icache_ctrl_inst (
        .clk          (clk),
        .rst          (rst),
        .inst_req     (inst_req),
        .inst_addr    (inst_addr),
        .hit          (hit),
        .hit_word     (hit_word),
        .arready      (arready),
        .rdata        (rdata),
        .rvalid       (rvalid),
        .rlast        (rlast),
        .array_index  (array_index),
        .array_word   (array_word),
        .lookup_tag   (lookup_tag),
        .fill_we      (fill_we),
        .fill_word    (fill_word),
        .fill_done    (fill_done),
        .hit_access   (hit_access),
        .inst_data_ok (inst_data_ok),
        .inst_rdata   (inst_rdata),
        .arvalid      (arvalid),
        .araddr       (araddr),
        .arlen        (arlen)
    );

    icache_tag_array icache_tag_array_inst (
        .clk         (clk),
        .rst         (rst),
        .array_index (array_index),
        .lookup_tag  (lookup_tag),
        .fill_done   (fill_done),
        .victim_way  (victim_way),
        .hit         (hit),
        .hit_way     (hit_way)
    );

    icache_data_array icache_data_array_inst (
        .clk         (clk),
        .array_index (array_index),
        .array_word  (array_word),
        .fill_we     (fill_we),
        .fill_word   (fill_word),
        .victim_way  (victim_way),
        .rdata       (rdata),
        .hit_way     (hit_way),
        .hit_word    (hit_word)
    );

    icache_plru icache_plru_inst (
        .clk         (clk),
        .rst         (rst),
        .array_index (array_index),
        .hit_access  (hit_access),
        .hit_way     (hit_way),
        .fill_done   (fill_done),
        .victim_way  (victim_way)
    );

endmodule

// File: sim/axi_rd_mem_model.sv
`timescale 1ns/100ps

module axi_rd_mem_model
    import bus_pkg::*;
#(
    parameter logic [31:0] seed_init = 32'h1
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  arvalid,
    input  logic [31:0]           araddr,
    input  logic [arlen_bits-1:0] arlen,
    output logic                  arready,
    output logic [31:0]           rdata,
    output logic                  rvalid,
    output logic                  rlast,
    output logic [31:0]           read_count,
    output logic [31:0]           last_araddr,
    output logic [arlen_bits-1:0] last_arlen
);

    integer                seed;
    logic                  busy;
    logic [31:0]           base;
    logic [arlen_bits-1:0] len;
    logic [arlen_bits-1:0] beat;
    logic [1:0]            wait_cnt;

    // 0 to 3 idle cycles
    function automatic logic [1:0] draw_delay();
        logic [31:0] r;
        r = $random(seed);
        return r[1:0];
    endfunction

    initial begin
        seed    = seed_init;
        arready = 1'b0;
        rvalid  = 1'b0;
        rlast   = 1'b0;
        rdata   = '0;
    end

    always @(posedge clk) begin
        if (rst) begin
            arready    <= 1'b0;
            rvalid     <= 1'b0;
            rlast      <= 1'b0;
            busy       <= 1'b0;
            read_count <= '0;
            wait_cnt   <= draw_delay();
        end else if (!busy) begin
            if (arvalid && arready) begin
                arready     <= 1'b0;
                busy        <= 1'b1;
                base        <= araddr;
                len         <= arlen;
                beat        <= '0;
                read_count  <= read_count + 1;
                last_araddr <= araddr;
                last_arlen  <= arlen;
                wait_cnt    <= draw_delay();
            end else if (arvalid) begin
                if (wait_cnt == 0) begin
                    arready <= 1'b1;
                end else begin
                    wait_cnt <= wait_cnt - 1'b1;
                end
            end
        end else begin
            // a beat shown last cycle was taken at this edge
            if (rvalid) begin
                rvalid   <= 1'b0;
                rlast    <= 1'b0;
                beat     <= beat + 1'b1;
                wait_cnt <= draw_delay();
                if (rlast) begin
                    busy <= 1'b0;
                end
            end else if (wait_cnt == 0) begin
                rvalid <= 1'b1;
                rdata  <= ~(base + {beat, 2'b00});
                rlast  <= (beat == len);
            end else begin
                wait_cnt <= wait_cnt - 1'b1;
            end
        end
    end

endmodule

// File: sim/tb_icache_top.sv
`timescale 1ns/100ps

module tb_icache_top
    import cache_pkg::*, bus_pkg::*;
;

    localparam int          clk_period  = 40;
    localparam int          num_entries = 22;
    localparam logic [31:0] seed        = 32'h5b5d0526;
    localparam int          cycle_limit = num_entries * 40;

    logic                  clk;
    logic                  rst;
    logic                  inst_req;
    logic [31:0]           inst_addr;
    logic                  inst_data_ok;
    logic [31:0]           inst_rdata;
    logic                  arvalid;
    logic                  arready;
    logic [31:0]           araddr;
    logic [arlen_bits-1:0] arlen;
    logic [31:0]           rdata;
    logic                  rvalid;
    logic                  rlast;
    logic [31:0]           read_count;
    logic [31:0]           last_araddr;
    logic [arlen_bits-1:0] last_arlen;

    int cycles;
    int errors;
    int n_entries;

    logic [31:0]           tbl_addr   [num_entries];
    bit                    tbl_reset  [num_entries];
    logic [31:0]           tbl_data   [num_entries];
    bit                    tbl_read   [num_entries];
    logic [arlen_bits-1:0] tbl_len    [num_entries];
    logic [31:0]           tbl_araddr [num_entries];

    // reference cache state for the expected hit or miss
    logic [tag_bits-1:0] model_tag   [num_ways][num_sets];
    bit                  model_valid [num_ways][num_sets];
    plru_t               model_tree  [num_sets];

    icache_top icache_top_inst (
        .clk          (clk),
        .rst          (rst),
        .inst_req     (inst_req),
        .inst_addr    (inst_addr),
        .inst_data_ok (inst_data_ok),
        .inst_rdata   (inst_rdata),
        .arvalid      (arvalid),
        .arready      (arready),
        .araddr       (araddr),
        .arlen        (arlen),
        .rdata        (rdata),
        .rvalid       (rvalid),
        .rlast        (rlast)
    );

    axi_rd_mem_model #(.seed_init(seed)) axi_rd_mem_model_inst (
        .clk         (clk),
        .rst         (rst),
        .arvalid     (arvalid),
        .araddr      (araddr),
        .arlen       (arlen),
        .arready     (arready),
        .rdata       (rdata),
        .rvalid      (rvalid),
        .rlast       (rlast),
        .read_count  (read_count),
        .last_araddr (last_araddr),
        .last_arlen  (last_arlen)
    );

    function automatic logic [31:0] map_phys(input logic [31:0] a);
        if (a[31:29] == seg_kseg0 || a[31:29] == seg_kseg1) begin
            return {3'b000, a[28:0]};
        end
        return a;
    endfunction

    task automatic model_clear();
        for (int s = 0; s < num_sets; s++) begin
            model_tree[s] = '0;
            for (int w = 0; w < num_ways; w++) begin
                model_valid[w][s] = 1'b0;
            end
        end
    endtask

    // true when the access must go to the bus
    function automatic bit predict_miss(input logic [31:0] a);
        logic [6:0]  idx;
        logic [19:0] tag;
        logic [1:0]  way;
        bit          found;
        if (a[31:29] == seg_kseg1) begin
            return 1'b1;
        end
        idx   = a[11:5];
        tag   = a[31:12];
        found = 1'b0;
        way   = 2'd0;
        for (int w = 0; w < num_ways; w++) begin
            if (model_valid[w][idx] && model_tag[w][idx] == tag) begin
                found = 1'b1;
                way   = w[1:0];
            end
        end
        if (!found) begin
            if (!model_tree[idx].root) begin
                way = model_tree[idx].lo ? 2'd1 : 2'd0;
            end else begin
                way = model_tree[idx].hi ? 2'd3 : 2'd2;
            end
            model_valid[way][idx] = 1'b1;
            model_tag[way][idx]   = tag;
        end
        model_tree[idx].root = (way < 2);
        if (way < 2) begin
            model_tree[idx].lo = (way == 0);
        end else begin
            model_tree[idx].hi = (way == 2);
        end
        return !found;
    endfunction

    task automatic add_entry(input logic [31:0] a, input bit do_reset);
        bit uncached;
        uncached = (a[31:29] == seg_kseg1);
        if (do_reset) begin
            model_clear();
        end
        tbl_addr[n_entries]   = a;
        tbl_reset[n_entries]  = do_reset;
        tbl_data[n_entries]   = ~map_phys(a);
        tbl_read[n_entries]   = predict_miss(a);
        tbl_len[n_entries]    = uncached ? single_burst_len : line_burst_len;
        tbl_araddr[n_entries] = uncached ? map_phys(a) : (map_phys(a) & 32'hffff_ffe0);
        n_entries++;
    endtask

    task automatic build_table();
        // cold miss then the rest of the line
        add_entry(32'h8000_1048, 1'b0);
        add_entry(32'h8000_1040, 1'b0);
        add_entry(32'h8000_105c, 1'b0);
        // uncached address read twice
        add_entry(32'ha000_2004, 1'b0);
        add_entry(32'ha000_2004, 1'b0);
        // five tags in set 5
        add_entry(32'h8001_00a0, 1'b0);
        add_entry(32'h8001_10a0, 1'b0);
        add_entry(32'h8001_20a0, 1'b0);
        add_entry(32'h8001_30a0, 1'b0);
        add_entry(32'h8001_40a0, 1'b0);
        add_entry(32'h8001_00a0, 1'b0);
        add_entry(32'h8001_20a0, 1'b0);
        // a hit in set 9 protects way 0
        add_entry(32'h8002_0120, 1'b0);
        add_entry(32'h8002_1120, 1'b0);
        add_entry(32'h8002_2120, 1'b0);
        add_entry(32'h8002_3120, 1'b0);
        add_entry(32'h8002_0120, 1'b0);
        add_entry(32'h8002_4120, 1'b0);
        add_entry(32'h8002_0120, 1'b0);
        add_entry(32'h8002_1120, 1'b0);
        // second reset drops the cached line
        add_entry(32'h8000_1048, 1'b1);
        add_entry(32'h8000_105c, 1'b0);
    endtask

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        cycles = 0;
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the cache stopped responding after %0d cycles", cycles);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        int          lat;
        logic [31:0] reads_before;
        logic [31:0] reads_done;
        rst       = 1'b1;
        inst_req  = 1'b0;
        inst_addr = '0;
        errors    = 0;
        n_entries = 0;
        model_clear();
        build_table();
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        repeat (4) begin
            @(negedge clk);
            assert (!inst_data_ok && !arvalid) else begin
                errors++;
                $display("[ERROR] %0t: output active after reset with no request", $time);
            end
        end
        for (int i = 0; i < num_entries; i++) begin
            if (tbl_reset[i]) begin
                @(posedge clk);
                rst <= 1'b1;
                repeat (2) @(posedge clk);
                rst <= 1'b0;
            end
            reads_before = read_count;
            @(posedge clk);
            inst_req  <= 1'b1;
            inst_addr <= tbl_addr[i];
            @(posedge clk);
            inst_req  <= 1'b0;
            lat = 0;
            do begin
                @(negedge clk);
                lat++;
            end while (!inst_data_ok);
            reads_done = read_count - reads_before;
            assert (inst_rdata == tbl_data[i]) else begin
                errors++;
                $display("[ERROR] %0t: entry %0d data %h, expected %h",
                         $time, i, inst_rdata, tbl_data[i]);
            end
            assert (reads_done == (tbl_read[i] ? 1 : 0)) else begin
                errors++;
                $display("[ERROR] %0t: entry %0d saw %0d bus reads, expected %0d",
                         $time, i, reads_done, tbl_read[i]);
            end
            if (tbl_read[i]) begin
                assert (last_araddr == tbl_araddr[i] && last_arlen == tbl_len[i]) else begin
                    errors++;
                    $display("[ERROR] %0t: entry %0d araddr %h arlen %0d, expected %h %0d",
                             $time, i, last_araddr, last_arlen, tbl_araddr[i], tbl_len[i]);
                end
            end else begin
                assert (lat == 1) else begin
                    errors++;
                    $display("[ERROR] %0t: entry %0d hit took %0d cycles", $time, i, lat);
                end
            end
        end
        $display("checks done, errors: %0d", errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: vlog.f
design/cache_pkg.sv
design/bus_pkg.sv
design/icache_ctrl.sv
design/icache_tag_array.sv
design/icache_data_array.sv
design/icache_plru.sv
design/icache_top.sv
sim/axi_rd_mem_model.sv
sim/tb_icache_top.sv
